// ==== src/mul_pkg.sv ====
package mul_pkg;

    // operand and product widths
    localparam int OP_W   = 16;
    localparam int PROD_W = 2 * OP_W;

    // carry-save array shape
    localparam int ROWS_PER_STAGE = 4;
    localparam int NUM_STAGES     = OP_W / ROWS_PER_STAGE;

    // entry register + csa stages + final adder register
    localparam int PIPE_LATENCY = NUM_STAGES + 2;

    typedef logic [OP_W-1:0]   operand_t;
    typedef logic [PROD_W-1:0] product_t;    // product or accumulator vector

endpackage

// ==== src/mul_stage_if.sv ====
`timescale 1ns/1ps

interface mul_stage_if
    import mul_pkg::*;
();

    logic     valid;        // item qualifier, no back-pressure
    operand_t a;
    operand_t b;
    product_t acc_sum;      // partial sum vector
    product_t acc_carry;    // partial carry vector, already weighted

    modport src (
        output valid,
        output a,
        output b,
        output acc_sum,
        output acc_carry
    );

    modport dst (
        input valid,
        input a,
        input b,
        input acc_sum,
        input acc_carry
    );

endinterface

// ==== src/mul_operand_reg.sv ====
`timescale 1ns/1ps

module mul_operand_reg
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    mul_stage_if.src out
);

    // valid bit of the entry register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    // operands only load with a valid pair
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.a <= a;
            out.b <= b;
        end
    end

    // accumulator starts empty for every item
    always_ff @(posedge clk) begin
        out.acc_sum   <= '0;
        out.acc_carry <= '0;
    end

endmodule

// ==== src/mul_csa_stage.sv ====
`timescale 1ns/1ps

module mul_csa_stage
    import mul_pkg::*;
#(
    parameter int STAGE = 0
) (
    input  logic     clk,
    input  logic     rst_n,
    mul_stage_if.dst prev,
    mul_stage_if.src next
);

    localparam int BASE = STAGE * ROWS_PER_STAGE;    // bit of a for the first row

    product_t row     [ROWS_PER_STAGE];
    product_t s_chain [ROWS_PER_STAGE+1];
    product_t c_chain [ROWS_PER_STAGE+1];
    product_t maj     [ROWS_PER_STAGE];

    // partial-product rows, each gated by one bit of a
    for (genvar r = 0; r < ROWS_PER_STAGE; r++) begin : g_row
        assign row[r] = prev.a[BASE + r] ? (product_t'(prev.b) << (BASE + r)) : '0;
    end

    assign s_chain[0] = prev.acc_sum;
    assign c_chain[0] = prev.acc_carry;

    // chain of 3:2 counters, one row absorbed per counter
    for (genvar r = 0; r < ROWS_PER_STAGE; r++) begin : g_csa
        assign maj[r] = (s_chain[r] & c_chain[r])
                      | (s_chain[r] & row[r])
                      | (c_chain[r] & row[r]);

        assign s_chain[r+1] = s_chain[r] ^ c_chain[r] ^ row[r];
        assign c_chain[r+1] = maj[r] << 1;    // top carry drops, product fits in 32 bits
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next.valid <= 1'b0;
        end else begin
            next.valid <= prev.valid;
        end
    end

    // payload follows the item, held while the link is idle
    always_ff @(posedge clk) begin
        if (prev.valid) begin
            next.a         <= prev.a;
            next.b         <= prev.b;
            next.acc_sum   <= s_chain[ROWS_PER_STAGE];
            next.acc_carry <= c_chain[ROWS_PER_STAGE];
        end
    end

endmodule

// ==== src/ks_adder.sv ====
`timescale 1ns/1ps

module ks_adder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LEVELS = (WIDTH > 1) ? $clog2(WIDTH) : 0;

    // group generate and propagate after each prefix level
    logic [WIDTH-1:0] g [0:LEVELS];
    logic [WIDTH-1:0] p [0:LEVELS];

    assign g[0] = x & y;
    assign p[0] = x ^ y;

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int SPAN = 1 << lvl;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < SPAN) begin : g_pass
                // group already reaches bit 0
                assign g[lvl+1][i] = g[lvl][i];
                assign p[lvl+1][i] = 1'b0;
            end else if (i < 2 * SPAN) begin : g_gray
                assign g[lvl+1][i] = g[lvl][i] | (p[lvl][i] & g[lvl][i-SPAN]);
                assign p[lvl+1][i] = 1'b0;     // no carry-in, propagate no longer needed
            end else begin : g_black
                assign g[lvl+1][i] = g[lvl][i] | (p[lvl][i] & g[lvl][i-SPAN]);
                assign p[lvl+1][i] = p[lvl][i] & p[lvl][i-SPAN];
            end
        end
    end

    // sum bit is local propagate xor carry from the bits below
    for (genvar i = 0; i < WIDTH; i++) begin : g_sum
        if (i == 0) begin : g_lsb
            assign sum[i] = p[0][i];
        end else begin : g_upper
            assign sum[i] = p[0][i] ^ g[LEVELS][i-1];
        end
    end

    assign cout = g[LEVELS][WIDTH-1];

endmodule

// ==== src/mul_resolve.sv ====
`timescale 1ns/1ps

module mul_resolve
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    mul_stage_if.dst prev,
    output logic     out_valid,
    output product_t product
);

    product_t sum_w;

    // final carry-propagate add of the redundant pair
    ks_adder #(
        .WIDTH (PROD_W)
    ) u_add (
        .x    (prev.acc_sum),
        .y    (prev.acc_carry),
        .sum  (sum_w),
        .cout ()                // always zero for a 16x16 product
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prev.valid) begin
            product <= sum_w;
        end
    end

endmodule

// ==== src/mul16_top.sv ====
`timescale 1ns/1ps

module mul16_top
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output product_t product
);

    // link 0 from the entry register, last link into the adder
    mul_stage_if link [0:NUM_STAGES] ();

    mul_operand_reg u_entry (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .out      (link[0])
    );

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        mul_csa_stage #(
            .STAGE (i)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .prev  (link[i]),
            .next  (link[i+1])
        );
    end

    mul_resolve u_resolve (
        .clk       (clk),
        .rst_n     (rst_n),
        .prev      (link[NUM_STAGES]),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

// ==== testbench/mul16_asserts.sv ====
`timescale 1ns/1ps

module mul16_asserts
    import mul_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     out_valid,
    input product_t product
);

    logic [3:0] since_rst;    // clean edges since reset, saturating

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            since_rst <= '0;
        end else if (since_rst < PIPE_LATENCY) begin
            since_rst <= since_rst + 1'b1;
        end
    end

    a_reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high in the cycle after a reset cycle");

    // full window without reset, so the pipeline carries the pattern unchanged
    a_valid_delay: assert property (@(posedge clk)
        (since_rst == PIPE_LATENCY) |-> (out_valid == $past(in_valid, PIPE_LATENCY)))
        else $error("out_valid does not follow in_valid %0d cycles later", PIPE_LATENCY);

    a_product_known: assert property (@(posedge clk) out_valid |-> !$isunknown(product))
        else $error("product has unknown bits while out_valid is high");

endmodule

bind mul16_top mul16_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .product   (product)
);

// ==== testbench/tb_mul16.sv ====
`timescale 1ns/1ps

module tb_mul16
    import mul_pkg::*;
();

    localparam int DRAIN_LIMIT = 64;    // cycles allowed for the pipeline to empty

    typedef struct {
        operand_t a;
        operand_t b;
        logic     gap;          // one idle cycle before this pair
        product_t expected;
    } vec_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    vec_t     table_q[$];
    product_t exp_q[$];                          // products still in flight
    logic [PIPE_LATENCY-1:0] valid_hist = '0;    // in_valid as sampled by the DUT
    logic [31:0] lfsr_state = 32'h14e1_3802;
    int err_count    = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    mul16_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // taps 32,22,2,1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    function automatic void add_vec(input operand_t va, input operand_t vb, input logic gap);
        vec_t v;
        v.a        = va;
        v.b        = vb;
        v.gap      = gap;
        v.expected = product_t'(va) * product_t'(vb);    // plain unsigned product
        table_q.push_back(v);
    endfunction

    task automatic apply_table();
        foreach (table_q[i]) begin
            if (table_q[i].gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            a        <= table_q[i].a;
            b        <= table_q[i].b;
            exp_q.push_back(table_q[i].expected);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d products never came out of the pipeline", exp_q.size());
            err_count++;
        end
    endtask

    // reset seen on two edges, in-flight pairs are dropped
    task automatic apply_reset();
        @(posedge clk);
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        @(posedge clk);
        exp_q.delete();
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[PIPE_LATENCY-2:0], in_valid};
        end
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        check_val("out_valid", out_valid, valid_hist[PIPE_LATENCY-1]);
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("product %h came out with no pair outstanding", product);
                err_count++;
            end else begin
                check_val("product", product, exp_q.pop_front());
            end
        end
    end

    initial begin
        int errs;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_count;
        table_q.delete();
        add_vec(16'h0000, 16'hFFFF, 1'b0);
        add_vec(16'h0000, 16'h1234, 1'b0);
        add_vec(16'hABCD, 16'h0000, 1'b0);
        add_vec(16'h0001, 16'hBEEF, 1'b0);
        add_vec(16'hFFFF, 16'h0001, 1'b0);
        add_vec(16'hFFFF, 16'hFFFF, 1'b0);    // 0xfffe0001
        for (int i = 0; i < OP_W; i++) begin
            add_vec(16'h1 << i, 16'h1 << (OP_W - 1 - i), 1'b0);
            add_vec(16'h1 << i, 16'hFFFF, 1'b0);
        end
        add_vec(16'hAAAA, 16'h5555, 1'b0);
        add_vec(16'h5555, 16'h5555, 1'b0);
        add_vec(16'hAAAA, 16'hAAAA, 1'b0);
        add_vec(16'h5555, 16'hAAAA, 1'b0);
        apply_table();
        wait_drain();
        finish_test("1 corner products", errs);

        errs = err_count;
        table_q.delete();
        for (int i = 0; i < 200; i++) begin
            add_vec(operand_t'(take_bits(OP_W)), operand_t'(take_bits(OP_W)), 1'b0);
        end
        apply_table();
        wait_drain();
        finish_test("2 random back to back", errs);

        errs = err_count;
        table_q.delete();
        for (int i = 0; i < 100; i++) begin
            add_vec(operand_t'(take_bits(OP_W)), operand_t'(take_bits(OP_W)),
                    take_bits(1) != 0);
        end
        apply_table();
        wait_drain();
        finish_test("3 random gaps", errs);

        errs = err_count;
        table_q.delete();
        for (int i = 0; i < 8; i++) begin
            add_vec(operand_t'(take_bits(OP_W)), operand_t'(take_bits(OP_W)), 1'b0);
        end
        apply_table();
        apply_reset();    // hits while half of the pairs are still in flight
        repeat (3) begin
            @(negedge clk);
            check_val("out_valid after reset", out_valid, 1'b0);
        end
        table_q.delete();
        for (int i = 0; i < 8; i++) begin
            add_vec(operand_t'(take_bits(OP_W)), operand_t'(take_bits(OP_W)), 1'b0);
        end
        apply_table();
        wait_drain();
        finish_test("4 mid-run reset", errs);

        for (int g = 0; g < NUM_STAGES; g++) begin
            errs = err_count;
            table_q.delete();
            add_vec(16'hF << (ROWS_PER_STAGE * g), 16'hFFFF, 1'b0);
            add_vec(16'h9 << (ROWS_PER_STAGE * g), 16'hFFFF, 1'b0);
            add_vec(16'h1 << (ROWS_PER_STAGE * g), 16'hFFFF, 1'b0);
            add_vec(operand_t'(take_bits(4)) << (ROWS_PER_STAGE * g), 16'hFFFF, 1'b1);
            apply_table();
            wait_drain();
            finish_test($sformatf("5.%0d bit group %0d of a", g, g), errs);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/mul_pkg.sv
src/mul_stage_if.sv
src/mul_operand_reg.sv
src/mul_csa_stage.sv
src/ks_adder.sv
src/mul_resolve.sv
src/mul16_top.sv
testbench/mul16_asserts.sv
testbench/tb_mul16.sv

// ==== Bender.yml ====
package:
  name: mul16

sources:
  - src/mul_pkg.sv
  - src/mul_stage_if.sv
  - src/mul_operand_reg.sv
  - src/mul_csa_stage.sv
  - src/ks_adder.sv
  - src/mul_resolve.sv
  - src/mul16_top.sv
  - target: test
    files:
      - testbench/mul16_asserts.sv
      - testbench/tb_mul16.sv
